// File: hdl/rayViewPkg.sv
//*************************************************
// Shared widths, bus structs, VGA constants and the reset pose
// for the ray view display core. Modules import it in their body
// and use scoped names in their port lists.
//*************************************************
`default_nettype none

package rayViewPkg;

    // Fixed point format is Q12.12
    localparam int fixedFracBits = 12;

    typedef logic signed [23:0] fixedT;     // Coordinate or vector component
    typedef logic [9:0]         coordT;     // Pixel position
    typedef logic [10:0]        frameNumT;  // Free running frame count
    typedef logic [1:0]         levelT;     // One colour channel
    typedef logic [3:0]         cellIdxT;   // Map row or column

    typedef struct packed {
        levelT r;
        levelT g;
        levelT b;
    } rgbT;

    typedef struct packed {
        fixedT playerX;
        fixedT playerY;
        fixedT facingX;  // Heading vector
        fixedT facingY;
        fixedT vplaneX;  // View plane vector
        fixedT vplaneY;
    } poseT;

    typedef struct packed {
        logic left;
        logic right;
        logic forward;
        logic back;
    } moveT;

    typedef struct packed {
        coordT h;
        coordT v;
        logic  visible;     // Inside 640x480
        logic  activeRows;  // v below 480, host may write the pose
        logic  frameTick;   // Single cycle at h=0, v=0
    } scanT;

    // 640x480 timing, counts in pixel clocks and lines
    localparam int hVisible   = 640;
    localparam int hSyncStart = 656;
    localparam int hSyncEnd   = 752;
    localparam int hTotal     = 800;
    localparam int vVisible   = 480;
    localparam int vSyncStart = 490;
    localparam int vSyncEnd   = 492;
    localparam int vTotal     = 525;

    localparam int halfHeight  = vVisible / 2;  // Ceiling above, floor below
    localparam int borderLeft  = 66;
    localparam int borderRight = 574;

    localparam fixedT fixedOne  = fixedT'(1 << fixedFracBits);
    localparam fixedT fixedHalf = fixedT'(1 << (fixedFracBits - 1));

    // Start in the middle of cell (1,13), looking up the map
    localparam fixedT playerStartX = fixedOne + fixedHalf;
    localparam fixedT playerStartY = fixedT'(13 * fixedOne + fixedHalf);
    localparam fixedT facingStartX = '0;
    localparam fixedT facingStartY = -fixedOne;
    localparam fixedT vplaneStartX = fixedHalf;  // Gives a narrow FOV
    localparam fixedT vplaneStartY = '0;

    localparam poseT startPose = '{
        playerX: playerStartX, playerY: playerStartY,
        facingX: facingStartX, facingY: facingStartY,
        vplaneX: vplaneStartX, vplaneY: vplaneStartY
    };

endpackage

`default_nettype wire

// File: hdl/vgaTiming.sv
//*************************************************
// 640x480 VGA scan generator. Drives the scan position bus,
// registered active low syncs and a frame counter that steps
// once per completed frame.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module vgaTiming (
    input  logic                 clk,
    input  logic                 reset,
    output rayViewPkg::scanT     scan,
    output logic                 hsync,
    output logic                 vsync,
    output rayViewPkg::frameNumT frameNum
);

    import rayViewPkg::*;

    localparam coordT hLast   = coordT'(hTotal - 1);
    localparam coordT vLast   = coordT'(vTotal - 1);
    localparam coordT hSyncLo = coordT'(hSyncStart);
    localparam coordT hSyncHi = coordT'(hSyncEnd);
    localparam coordT vSyncLo = coordT'(vSyncStart);
    localparam coordT vSyncHi = coordT'(vSyncEnd);

    coordT hCount;   // Current pixel in line
    coordT vCount;   // Current line in frame
    coordT hNext;
    coordT vNext;
    logic  hWrap;
    logic  vWrap;

    assign hWrap = (hCount == hLast);
    assign vWrap = (vCount == vLast);

    // Next position, so the sync flops line up with the counters
    assign hNext = hWrap ? '0 : hCount + 1'b1;
    assign vNext = !hWrap ? vCount : (vWrap ? '0 : vCount + 1'b1);

    always_ff @(posedge clk) begin
        if (reset) begin
            hCount   <= '0;
            vCount   <= '0;
            frameNum <= '0;
            hsync    <= 1'b1;  // Inactive
            vsync    <= 1'b1;
        end else begin
            hCount <= hNext;
            vCount <= vNext;
            if (hWrap && vWrap) begin
                frameNum <= frameNum + 1'b1;  // Last pixel of the frame
            end
            // Low inside the sync window
            hsync <= !(hNext >= hSyncLo && hNext < hSyncHi);
            vsync <= !(vNext >= vSyncLo && vNext < vSyncHi);
        end
    end

    // Flags decoded straight from the counters
    assign scan = '{
        h:          hCount,
        v:          vCount,
        visible:    (hCount < coordT'(hVisible)) && (vCount < coordT'(vVisible)),
        activeRows: (vCount < coordT'(vVisible)),
        frameTick:  (hCount == '0) && (vCount == '0)
    };

endmodule

`default_nettype wire

// File: hdl/playerState.sv
//*************************************************
// Player pose registers beside the renderer. Loads the start pose
// on reset, takes host writes on a valid/ready handshake during the
// active rows, and applies button motion once per frame.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module playerState #(
    parameter rayViewPkg::fixedT moveStep = 24'sd40  // Motion per frame
) (
    input  logic             clk,
    input  logic             reset,
    input  rayViewPkg::scanT scan,
    input  rayViewPkg::moveT move,
    input  logic             poseValid,
    input  rayViewPkg::poseT pose,
    output logic             poseReady,
    output rayViewPkg::poseT current
);

    import rayViewPkg::*;

    logic  poseTake;   // Handshake completes this edge
    logic  stepFrame;  // Motion allowed this edge
    fixedT nextX;
    fixedT nextY;

    // Host may only write while rows are being drawn
    assign poseReady = scan.activeRows;
    assign poseTake  = poseValid && poseReady;

    // Tick sits in row 0, so a write offered then is taken instead
    assign stepFrame = scan.frameTick;

    // Axis aligned motion, left and forward take precedence
    always_comb begin
        nextX = current.playerX;
        if (move.left) begin
            nextX = current.playerX - moveStep;
        end else if (move.right) begin
            nextX = current.playerX + moveStep;
        end

        nextY = current.playerY;
        if (move.forward) begin
            nextY = current.playerY - moveStep;  // Up the map
        end else if (move.back) begin
            nextY = current.playerY + moveStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            current <= startPose;
        end else if (poseTake) begin
            current <= pose;  // Whole pose replaced
        end else if (stepFrame) begin
            // Facing and view plane stay put
            current.playerX <= nextX;
            current.playerY <= nextY;
        end
    end

endmodule

`default_nettype wire

// File: hdl/mapCells.sv
//*************************************************
// Fixed 16x16 map built from logic. Returns the colour level of
// the addressed cell for the overlay.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module mapCells (
    input  rayViewPkg::cellIdxT row,
    input  rayViewPkg::cellIdxT col,
    output rayViewPkg::levelT   val
);

    import rayViewPkg::*;

    logic outerRing;  // Solid wall around the edge
    logic pillar;     // Regular grid of inner blocks

    assign outerRing = (row == '0) || (row == '1) || (col == '0) || (col == '1);

    // Row and column both 2 modulo 4
    assign pillar = (row[1:0] == 2'd2) && (col[1:0] == 2'd2);

    always_comb begin
        if (outerRing) begin
            val = levelT'(3);
        end else if (pillar) begin
            val = levelT'(2);
        end else begin
            val = '0;  // Open floor
        end
    end

endmodule

`default_nettype wire

// File: hdl/pixelComposer.sv
//*************************************************
// Per pixel colour selection. Draws ceiling, floor and side
// borders, with the optional map overlay and player marker on
// top. Purely combinational, blanked outside the visible area.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module pixelComposer #(
    parameter int mapScale = 4  // log2 of map cell size in pixels
) (
    input  rayViewPkg::scanT    scan,
    input  logic                showMap,
    input  rayViewPkg::poseT    current,
    input  rayViewPkg::levelT   mapVal,
    output rayViewPkg::cellIdxT mapRow,
    output rayViewPkg::cellIdxT mapCol,
    output rayViewPkg::rgbT     rgb
);

    import rayViewPkg::*;

    // 16 cells plus the closing gridline
    localparam int overlaySize = (16 << mapScale) + 1;

    localparam rgbT playerPixelColour = '{r: 2'd3, g: 2'd3, b: 2'd0};  // Yellow
    localparam rgbT playerCellColour  = '{r: 2'd0, g: 2'd1, b: 2'd0};  // Dark green
    localparam rgbT gridColour        = '{r: 2'd0, g: 2'd0, b: 2'd1};
    localparam rgbT borderColour      = '{r: 2'd1, g: 2'd0, b: 2'd1};  // Dark purple
    localparam rgbT ceilingColour     = '{r: 2'd1, g: 2'd1, b: 2'd1};
    localparam rgbT floorColour       = '{r: 2'd2, g: 2'd2, b: 2'd2};

    logic    inOverlay;
    logic    inGridline;
    logic    inPlayerCell;
    logic    inPlayerPixel;
    logic    inBorder;
    logic    inCeiling;
    cellIdxT playerCol;  // Integer part of the position
    cellIdxT playerRow;
    rgbT     colour;     // Before blanking

    // Cell under the beam
    assign mapCol = scan.h[mapScale +: 4];
    assign mapRow = scan.v[mapScale +: 4];

    assign playerCol = current.playerX[fixedFracBits +: 4];
    assign playerRow = current.playerY[fixedFracBits +: 4];

    assign inOverlay = showMap
                       && (scan.h < coordT'(overlaySize))
                       && (scan.v < coordT'(overlaySize));

    // First pixel row or column of each cell
    assign inGridline = inOverlay
                        && ((scan.h[mapScale-1:0] == '0) || (scan.v[mapScale-1:0] == '0));

    assign inPlayerCell = inOverlay && (mapCol == playerCol) && (mapRow == playerRow);

    // Top fraction bits pick the pixel inside the cell
    assign inPlayerPixel = inPlayerCell
        && (scan.h[mapScale-1:0] == current.playerX[fixedFracBits-1 -: mapScale])
        && (scan.v[mapScale-1:0] == current.playerY[fixedFracBits-1 -: mapScale]);

    assign inBorder  = (scan.h < coordT'(borderLeft)) || (scan.h >= coordT'(borderRight));
    assign inCeiling = (scan.v < coordT'(halfHeight));

    // Priority chain, overlay above everything else
    always_comb begin
        if (inPlayerPixel) begin
            colour = playerPixelColour;
        end else if (inPlayerCell) begin
            colour = playerCellColour;
        end else if (inGridline) begin
            colour = gridColour;
        end else if (inOverlay) begin
            colour = '{r: '0, g: '0, b: mapVal};  // Cell level in blue
        end else if (inBorder) begin
            colour = borderColour;
        end else if (inCeiling) begin
            colour = ceilingColour;
        end else begin
            colour = floorColour;
        end
    end

    assign rgb = scan.visible ? colour : '0;  // Black in blanking

endmodule

`default_nettype wire

// File: hdl/rayViewTop.sv
//*************************************************
// Top of the ray view display core. Connects scan timing, pose
// registers, map and pixel composer, and sets the motion step
// and map overlay scale for the blocks below.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module rayViewTop #(
    parameter rayViewPkg::fixedT moveStep = 24'sd40,  // Walking pace in LSB per frame
    parameter int                mapScale = 4         // 16 pixel map cells
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 showMap,
    input  rayViewPkg::moveT     move,
    input  logic                 poseValid,
    input  rayViewPkg::poseT     pose,
    output logic                 poseReady,
    output rayViewPkg::rgbT      rgb,
    output logic                 hsync,
    output logic                 vsync,
    output rayViewPkg::coordT    px,
    output rayViewPkg::coordT    py,
    output rayViewPkg::frameNumT frameNum
);

    import rayViewPkg::*;

    scanT    scan;
    poseT    current;
    cellIdxT mapRow;
    cellIdxT mapCol;
    levelT   mapVal;

    assign px = scan.h;
    assign py = scan.v;

    vgaTiming i_vgaTiming (
        .clk      (clk),
        .reset    (reset),
        .scan     (scan),
        .hsync    (hsync),
        .vsync    (vsync),
        .frameNum (frameNum)
    );

    playerState #(
        .moveStep (moveStep)
    ) i_playerState (
        .clk       (clk),
        .reset     (reset),
        .scan      (scan),
        .move      (move),
        .poseValid (poseValid),
        .pose      (pose),
        .poseReady (poseReady),
        .current   (current)
    );

    mapCells i_mapCells (
        .row (mapRow),
        .col (mapCol),
        .val (mapVal)
    );

    pixelComposer #(
        .mapScale (mapScale)
    ) i_pixelComposer (
        .scan    (scan),
        .showMap (showMap),
        .current (current),
        .mapVal  (mapVal),
        .mapRow  (mapRow),
        .mapCol  (mapCol),
        .rgb     (rgb)
    );

endmodule

`default_nettype wire

// File: verif/tbClock.sv
//*************************************************
// Testbench clock and reset source. 8 ns clock, reset
// held high for the first four rising edges.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module tbClock (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1 reset = 1'b0;  // Released 1 ns after the edge, like the other inputs
    end

endmodule

`default_nettype wire

// File: verif/rayViewTb.sv
//*************************************************
// Directed testbench for the ray view display core. Checks scan
// timing, background, map overlay, host pose writes and motion
// against its own colour model. Run through the Makefile.
//*************************************************
`default_nettype none
`timescale 1ns/100ps

module rayViewTb;

    import rayViewPkg::*;

    localparam int    frameCycles = 800 * 525;  // Pixel clocks per frame
    localparam fixedT stepLsb     = 24'sd40;    // Motion per frame tick
    localparam rgbT   yellow      = '{r: 2'd3, g: 2'd3, b: 2'd0};

    logic     clk;
    logic     reset;
    logic     showMap;
    moveT     move;
    logic     poseValid;
    poseT     pose;
    logic     poseReady;
    rgbT      rgb;
    logic     hsync;
    logic     vsync;
    coordT    px;
    coordT    py;
    frameNumT frameNum;

    int          errors = 0;
    logic [31:0] rnd    = 32'h12c6b1f3;  // xorshift state
    fixedT       tbX    = 24'sh001800;   // Expected pose, starts at (1.5, 13.5)
    fixedT       tbY    = 24'sh00d800;

    tbClock i_clock (.clk(clk), .reset(reset));

    rayViewTop i_dut (
        .clk       (clk),
        .reset     (reset),
        .showMap   (showMap),
        .move      (move),
        .poseValid (poseValid),
        .pose      (pose),
        .poseReady (poseReady),
        .rgb       (rgb),
        .hsync     (hsync),
        .vsync     (vsync),
        .px        (px),
        .py        (py),
        .frameNum  (frameNum)
    );

    function automatic logic [31:0] xorshift(logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Colour of one pixel, first matching rule wins
    function automatic rgbT expectColour(int h, int v, logic mapOn, fixedT x, fixedT y);
        int   row;
        int   col;
        int   lvl;
        logic overlay;
        logic inCell;
        row     = v / 16;  // 16 pixel map cells
        col     = h / 16;
        overlay = mapOn && h < 257 && v < 257;
        inCell  = overlay && col == int'(x[15:12]) && row == int'(y[15:12]);
        if (h >= 640 || v >= 480) return '0;  // Blanking
        if (inCell && h % 16 == int'(x[11:8]) && v % 16 == int'(y[11:8])) return yellow;
        if (inCell) return '{r: 2'd0, g: 2'd1, b: 2'd0};
        if (overlay && (h % 16 == 0 || v % 16 == 0)) return '{r: 2'd0, g: 2'd0, b: 2'd1};
        if (overlay) begin
            lvl = (row == 0 || row == 15 || col == 0 || col == 15) ? 3 :
                  (row % 4 == 2 && col % 4 == 2) ? 2 : 0;
            return '{r: 2'd0, g: 2'd0, b: levelT'(lvl)};
        end
        if (h < 66 || h >= 574) return '{r: 2'd1, g: 2'd0, b: 2'd1};  // Side borders
        if (v < 240) return '{r: 2'd1, g: 2'd1, b: 2'd1};
        return '{r: 2'd2, g: 2'd2, b: 2'd2};  // Floor
    endfunction

    task automatic checkRgb(string name, rgbT got, rgbT exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCoord(string name, coordT got, coordT exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic checkFrame(string name, frameNumT got, frameNumT exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic waitDriveSlot();
        @(posedge clk);
        #1;  // Inputs change here
    endtask

    // Outputs are sampled on the falling edge
    task automatic waitPixel(int h, int v);
        @(negedge clk);
        while (int'(px) != h || int'(py) != v) @(negedge clk);
    endtask

    task automatic checkPixel(int h, int v);
        waitPixel(h, v);
        checkRgb($sformatf("rgb at %0d,%0d", h, v), rgb, expectColour(h, v, showMap, tbX, tbY));
    endtask

    // Offer a pose and hold it until the handshake completes
    task automatic writePose(fixedT x, fixedT y);
        waitDriveSlot();
        pose      = '{playerX: x, playerY: y, facingX: '0, facingY: -24'sd4096,
                      vplaneX: 24'sd2048, vplaneY: '0};
        poseValid = 1'b1;
        @(negedge clk);
        while (!poseReady) @(negedge clk);  // Low only in blanking
        waitDriveSlot();  // Transfer edge just passed
        poseValid = 1'b0;
        tbX       = x;
        tbY       = y;
    endtask

    task automatic scanTimingTest();
        int eh;
        int ev;
        @(negedge clk);  // First cycle after reset sits at h=0, v=0
        eh = 0;
        ev = 0;
        for (int i = 0; i < frameCycles; i++) begin
            checkCoord("px", px, coordT'(eh));
            checkCoord("py", py, coordT'(ev));
            checkBit("hsync", hsync, !(eh >= 656 && eh < 752));  // Active low
            checkBit("vsync", vsync, !(ev >= 490 && ev < 492));
            checkFrame("frameNum", frameNum, frameNumT'(0));
            if (eh >= 640 || ev >= 480) checkRgb("rgb in blanking", rgb, '0);
            eh++;
            if (eh == 800) begin
                eh = 0;
                ev = (ev == 524) ? 0 : ev + 1;
            end
            @(negedge clk);
        end
        checkFrame("frameNum after one frame", frameNum, frameNumT'(1));
    endtask

    task automatic backgroundTest();
        int h;
        int v;
        for (int k = 0; k < 24; k++) begin
            rnd = xorshift(rnd);
            v   = k * 20 + int'(rnd % 20);  // Rows ascend, one frame is enough
            rnd = xorshift(rnd);
            h   = int'(rnd % 640);
            checkPixel(h, v);
        end
    endtask

    task automatic overlayTest();
        int h;
        int v;
        waitDriveSlot();
        showMap = 1'b1;
        for (int k = 0; k < 24; k++) begin
            rnd = xorshift(rnd);
            v   = k * 9 + int'(rnd % 9);  // Above the player row
            rnd = xorshift(rnd);
            h   = int'(rnd % 257);
            checkPixel(h, v);
        end
        checkPixel(24, 216);
        checkRgb("reset player pixel", rgb, yellow);
    endtask

    task automatic hostWriteTest();
        waitPixel(0, 490);  // Vertical blanking
        checkBit("poseReady in blanking", poseReady, 1'b0);
        writePose(fixedT'(5 * 4096 + 7 * 256 + 100), fixedT'(9 * 4096 + 3 * 256 + 50));
        @(negedge clk);
        checkCoord("px after write", px, 10'd1);  // Accepted on the first active pixel
        checkCoord("py after write", py, 10'd0);
        checkPixel(87, 147);  // Cell (5,9), sub pixel (7,3)
        checkRgb("written player pixel", rgb, yellow);
        checkPixel(88, 147);
        checkPixel(24, 216);  // Old spot cleared
    endtask

    task automatic motionTest();
        // 8 LSB short of the next sixteenth on both axes
        writePose(fixedT'(4 * 4096 + 6 * 256 - 8), fixedT'(7 * 4096 + 10 * 256 - 8));
        move = '{left: 1'b0, right: 1'b1, forward: 1'b0, back: 1'b1};
        waitPixel(0, 0);
        waitDriveSlot();  // Frame tick edge
        move = '0;
        tbX  = tbX + stepLsb;
        tbY  = tbY + stepLsb;
        checkPixel(69, 121);
        checkPixel(70, 122);
        checkRgb("moved player pixel", rgb, yellow);
        waitDriveSlot();
        move = '{left: 1'b1, right: 1'b1, forward: 1'b0, back: 1'b0};
        waitPixel(0, 0);
        waitDriveSlot();
        move = '0;
        tbX  = tbX - stepLsb;  // Left beats right
        checkPixel(69, 122);
        checkRgb("player pixel after left", rgb, yellow);
        checkPixel(70, 122);
    endtask

    initial begin
        showMap   = 1'b0;
        move      = '0;
        poseValid = 1'b0;
        pose      = '0;
        @(negedge reset);
        scanTimingTest();
        backgroundTest();
        overlayTest();
        hostWriteTest();
        motionTest();
        $display("Summary: %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Tests need about 7 frames
    initial begin
        repeat (12 * frameCycles) @(posedge clk);
        $display("Timeout: the tests did not finish within 12 frame times");
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hdl/rayViewPkg.sv
hdl/vgaTiming.sv
hdl/playerState.sv
hdl/mapCells.sv
hdl/pixelComposer.sv
hdl/rayViewTop.sv
verif/tbClock.sv
verif/rayViewTb.sv

// File: Makefile
# Verilator simulation of the ray view display core

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  make test   build and run the testbench, fails unless all checks pass"
	@echo "  make clean  remove the Verilator build directory"
	@echo "  make help   show this list"

obj_dir/VrayViewTb: all.f hdl/*.sv verif/*.sv
	verilator --binary --timing --timescale 1ns/100ps -f all.f --top-module rayViewTb

test: obj_dir/VrayViewTb
	@out="$$(./obj_dir/VrayViewTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir
